//--- src.f
logic/tpg_pkg.sv
logic/vga_sync_gen.sv
logic/sync_to_count.sv
logic/pattern_channel.sv
logic/video_out_align.sv
logic/test_pattern_top.sv
test/tb_test_pattern_sva.sv
test/tb_test_pattern_top.sv

//--- Bender.yml
package:
  name: test_pattern_gen

sources:
  - logic/tpg_pkg.sv
  - logic/vga_sync_gen.sv
  - logic/sync_to_count.sv
  - logic/pattern_channel.sv
  - logic/video_out_align.sv
  - logic/test_pattern_top.sv
  - target: test
    files:
      - test/tb_test_pattern_sva.sv
      - test/tb_test_pattern_top.sv

//--- test/tb_test_pattern_top.sv
`timescale 1ns/1ps

module tb_test_pattern_top;

  import tpg_pkg::*;

  // Small raster so a frame is only 800 cycles
  localparam int TOTAL_COLS    = 40;
  localparam int TOTAL_ROWS    = 20;
  localparam int ACTIVE_COLS   = 32;
  localparam int ACTIVE_ROWS   = 16;
  localparam int CHECKER_LOG2  = 2;
  localparam int CLK_PERIOD_NS = 100;
  localparam int FRAME_CYCLES  = TOTAL_COLS * TOTAL_ROWS;
  // Tests take about eight frames, one more as margin
  localparam int RUN_FRAMES    = 8;
  localparam video_t FULL_SCALE = '1;

  logic     i_Clk;
  logic     i_arst_n;
  pattern_e i_Pattern;
  logic     o_HSync;
  logic     o_VSync;
  logic     o_Locked;
  video_t   o_Red_Video;
  video_t   o_Grn_Video;
  video_t   o_Blu_Video;

  // Raster position rebuilt from the output syncs
  int   model_col;
  int   model_row;
  logic model_locked;
  logic prev_hsync;
  logic prev_vsync;
  // Cycles since the last rising sync, -1 before the first one
  int   line_cycles;
  int   frame_cycles;
  int   period_checks;
  int   n_errors;
  int   seed;

  test_pattern_top #(
    .TOTAL_COLS  (TOTAL_COLS),
    .TOTAL_ROWS  (TOTAL_ROWS),
    .ACTIVE_COLS (ACTIVE_COLS),
    .ACTIVE_ROWS (ACTIVE_ROWS),
    .CHECKER_LOG2(CHECKER_LOG2)
  ) u_test_pattern_top (.*);

  initial
  begin
    i_Clk = 1'b0;
    forever #(CLK_PERIOD_NS / 2) i_Clk = ~i_Clk;
  end

  // Watchdog
  initial
  begin
    #((RUN_FRAMES + 1) * FRAME_CYCLES * CLK_PERIOD_NS);
    $display("Timeout: tests still running, %0d errors so far", n_errors);
    $display("FAIL: see errors above");
    $finish;
  end

  //////////////////////////////
  // Compare tasks
  //////////////////////////////

  task automatic check_video(string name, video_t exp, video_t act);
    if (act !== exp)
    begin
      $display("[FAIL] %s: expected %0d, actual %0d", name, exp, act);
      n_errors++;
    end
  endtask

  task automatic check_bit(string name, logic exp, logic act);
    if (act !== exp)
    begin
      $display("[FAIL] %s: expected %b, actual %b", name, exp, act);
      n_errors++;
    end
  endtask

  // Line and frame lengths fit in a counter value
  task automatic check_count(string name, count_t exp, count_t act);
    if (act !== exp)
    begin
      $display("[FAIL] %s: expected %0d, actual %0d", name, exp, act);
      n_errors++;
    end
  endtask

  //////////////////////////////
  // Reference model
  //////////////////////////////

  // Component for channel ch (0 red, 1 green, 2 blue) at a visible pixel
  function automatic video_t expected_component(int ch, pattern_e pat, int col, int row);
    int   bar;
    logic lit;
    lit = 1'b0;
    bar = col / (ACTIVE_COLS / 8);
    if (bar > 7)
      bar = 7;
    if (col < ACTIVE_COLS && row < ACTIVE_ROWS)
    begin
      case (pat)
        PAT_RED, PAT_GREEN, PAT_BLUE: lit = (int'(pat) == ch + 1);
        PAT_CHECKER: lit = (((col >> CHECKER_LOG2) ^ (row >> CHECKER_LOG2)) & 1) != 0;
        // Bar index reads as {red, green, blue}
        PAT_BARS:    lit = ((bar >> (2 - ch)) & 1) != 0;
        PAT_BORDER:  lit = (row < 2) || (row >= ACTIVE_ROWS - 2) ||
                           (col < 2) || (col >= ACTIVE_COLS - 2);
        default:     lit = 1'b0;
      endcase
    end
    return lit ? FULL_SCALE : video_t'(0);
  endfunction

  // One clock of the model, outputs compared when check is set
  task automatic step_cycle(bit check, string name);
    string where;
    logic  visible;
    @(negedge i_Clk);
    if (line_cycles >= 0)
      line_cycles++;
    if (frame_cycles >= 0)
      frame_cycles++;
    if (o_HSync && !prev_hsync)
    begin
      if (line_cycles >= 0)
        check_count("line length", count_t'(TOTAL_COLS), count_t'(line_cycles));
      line_cycles = 0;
    end
    if (o_VSync && !prev_vsync)
    begin
      if (frame_cycles >= 0)
      begin
        check_count("frame length", count_t'(FRAME_CYCLES), count_t'(frame_cycles));
        period_checks++;
      end
    end
    // Active widths, seen as each sync drops
    if (!o_HSync && prev_hsync)
      check_count("last active column", count_t'(ACTIVE_COLS - 1), count_t'(model_col));
    if (!o_VSync && prev_vsync)
      check_count("last active row", count_t'(ACTIVE_ROWS - 1), count_t'(model_row));
    if (o_VSync && !prev_vsync)
    begin
      // First high VSync cycle is pixel (0,0)
      frame_cycles = 0;
      model_col    = 0;
      model_row    = 0;
      model_locked = 1'b1;
    end
    else if (o_HSync && !prev_hsync)
    begin
      model_col = 0;
      model_row++;
    end
    else if (o_HSync)
      model_col++;
    visible = o_HSync && o_VSync && model_locked;
    if (check)
    begin
      where = $sformatf("%s (%0d,%0d)", name, model_col, model_row);
      check_bit({where, " lock"}, model_locked, o_Locked);
      // Nothing may leave before the first frame
      if (!model_locked)
        check_bit({where, " hsync"}, 1'b0, o_HSync);
      check_video({where, " red"},
                  visible ? expected_component(0, i_Pattern, model_col, model_row) : '0,
                  o_Red_Video);
      check_video({where, " green"},
                  visible ? expected_component(1, i_Pattern, model_col, model_row) : '0,
                  o_Grn_Video);
      check_video({where, " blue"},
                  visible ? expected_component(2, i_Pattern, model_col, model_row) : '0,
                  o_Blu_Video);
    end
    prev_hsync = o_HSync;
    prev_vsync = o_VSync;
  endtask

  // New code, two cycles to reach the pixels, then compare
  task automatic run_pattern(pattern_e pat, string name, int cycles);
    i_Pattern = pat;
    repeat (2)
      step_cycle(1'b0, name);
    repeat (cycles)
      step_cycle(1'b1, name);
  endtask

  //////////////////////////////
  // Directed tests
  //////////////////////////////

  task automatic test_reset_lock();
    int waited;
    waited    = 0;
    i_Pattern = PAT_BORDER;
    repeat (3)
    begin
      // One reset cycle, outputs read half a period later
      @(posedge i_Clk);
      @(negedge i_Clk);
      check_bit("reset hsync", 1'b0, o_HSync);
      check_bit("reset vsync", 1'b0, o_VSync);
      check_bit("reset lock", 1'b0, o_Locked);
      check_video("reset red", '0, o_Red_Video);
      check_video("reset green", '0, o_Grn_Video);
      check_video("reset blue", '0, o_Blu_Video);
    end
    i_arst_n = 1'b1;
    // Border lights (0,0), so the lock cycle shows a white pixel
    while (!model_locked && waited < FRAME_CYCLES)
    begin
      step_cycle(1'b1, "reset_lock");
      waited++;
    end
    if (!model_locked)
    begin
      $display("Error: o_VSync never rose after reset");
      n_errors++;
    end
  endtask

  task automatic test_solid_colours();
    run_pattern(PAT_RED, "solid_red", FRAME_CYCLES);
    run_pattern(PAT_GREEN, "solid_green", FRAME_CYCLES);
    run_pattern(PAT_BLUE, "solid_blue", FRAME_CYCLES);
  endtask

  task automatic test_checker();
    run_pattern(PAT_CHECKER, "checker", FRAME_CYCLES);
  endtask

  task automatic test_bars_border();
    run_pattern(PAT_BARS, "bars", FRAME_CYCLES);
    run_pattern(PAT_BORDER, "border", FRAME_CYCLES);
  endtask

  // Ten black codes, two lines each, one frame in all
  task automatic test_black_codes();
    run_pattern(PAT_OFF, "code_0", 2 * TOTAL_COLS - 2);
    for (int code = 7; code < 16; code++)
      run_pattern(pattern_e'(code), $sformatf("code_%0d", code), 2 * TOTAL_COLS - 2);
  endtask

  task automatic test_random_switch();
    logic [3:0] first_code;
    logic [3:0] second_code;
    first_code  = 4'($random(seed));
    second_code = 4'($random(seed));
    if (second_code == first_code)
      second_code = first_code + 4'd1;
    // Second code arrives half a frame in
    run_pattern(pattern_e'(first_code), $sformatf("random_%0d", first_code),
                FRAME_CYCLES / 2);
    run_pattern(pattern_e'(second_code), $sformatf("switch_%0d", second_code),
                FRAME_CYCLES / 2 - 4);
    if (period_checks == 0)
    begin
      $display("Error: no complete frame was seen to measure its length");
      n_errors++;
    end
  endtask

  initial
  begin
    seed          = 32'h5ea2d635;
    n_errors      = 0;
    period_checks = 0;
    model_col     = 0;
    model_row     = 0;
    model_locked  = 1'b0;
    prev_hsync    = 1'b0;
    prev_vsync    = 1'b0;
    line_cycles   = -1;
    frame_cycles  = -1;
    // Lands after every always block is waiting, so the reset edge is seen
    i_arst_n     <= 1'b0;
    i_Pattern     = PAT_OFF;
    test_reset_lock();
    test_solid_colours();
    test_checker();
    test_bars_border();
    test_black_codes();
    test_random_switch();
    $display("Tests done with %0d errors", n_errors);
    if (n_errors == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

endmodule

//--- test/tb_test_pattern_sva.sv
`timescale 1ns/1ps

module tb_test_pattern_sva (
  input logic            i_Clk,
  input logic            i_arst_n,
  input logic            i_HSync,
  input logic            i_VSync,
  input logic            i_Locked,
  input tpg_pkg::video_t i_Red_Video,
  input tpg_pkg::video_t i_Grn_Video,
  input tpg_pkg::video_t i_Blu_Video
);

  import tpg_pkg::*;

  //////////////////////////////
  // Reset and lock
  //////////////////////////////

  // Inactive levels for as long as reset is held
  a_reset_quiet: assert property (@(posedge i_Clk)
    !i_arst_n |-> !i_HSync && !i_VSync && !i_Locked)
  else $error("Sync or lock high during reset");

  // Lock stays up for the rest of the run
  a_lock_sticky: assert property (@(posedge i_Clk) disable iff (!i_arst_n)
    i_Locked |=> i_Locked)
  else $error("o_Locked fell after rising");

  // Blanking carries black on every channel
  a_blank_black: assert property (@(posedge i_Clk) disable iff (!i_arst_n)
    (!i_HSync || !i_VSync) |->
      (i_Red_Video == video_t'(0)) && (i_Grn_Video == video_t'(0)) &&
      (i_Blu_Video == video_t'(0)))
  else $error("Video not black outside the active area");

endmodule

bind test_pattern_top tb_test_pattern_sva u_tb_test_pattern_sva (
  .i_Clk      (i_Clk),
  .i_arst_n   (i_arst_n),
  .i_HSync    (o_HSync),
  .i_VSync    (o_VSync),
  .i_Locked   (o_Locked),
  .i_Red_Video(o_Red_Video),
  .i_Grn_Video(o_Grn_Video),
  .i_Blu_Video(o_Blu_Video)
);

//--- logic/test_pattern_top.sv
`timescale 1ns/1ps

module test_pattern_top #(
  parameter int TOTAL_COLS   = 800,
  parameter int TOTAL_ROWS   = 525,
  parameter int ACTIVE_COLS  = 640,
  parameter int ACTIVE_ROWS  = 480,
  parameter int CHECKER_LOG2 = 5
) (
  input  logic              i_Clk,
  input  logic              i_arst_n,
  input  tpg_pkg::pattern_e i_Pattern,
  output logic              o_HSync,
  output logic              o_VSync,
  output logic              o_Locked,
  output tpg_pkg::video_t   o_Red_Video,
  output tpg_pkg::video_t   o_Grn_Video,
  output tpg_pkg::video_t   o_Blu_Video
);

  import tpg_pkg::*;

  // Raw syncs from the timing generator
  logic   w_gen_hsync;
  logic   w_gen_vsync;

  // Recovered raster position and delayed syncs
  count_t w_col;
  count_t w_row;
  logic   w_hsync_d;
  logic   w_vsync_d;
  logic   w_locked;

  // Pixel components, index 0 red, 1 green, 2 blue
  video_t w_rgb [3];

  //////////////////////////////
  // Timing and counting
  //////////////////////////////

  vga_sync_gen #(
    .TOTAL_COLS (TOTAL_COLS),
    .TOTAL_ROWS (TOTAL_ROWS),
    .ACTIVE_COLS(ACTIVE_COLS),
    .ACTIVE_ROWS(ACTIVE_ROWS)
  ) u_vga_sync_gen (
    .i_Clk   (i_Clk),
    .i_arst_n(i_arst_n),
    .o_HSync (w_gen_hsync),
    .o_VSync (w_gen_vsync)
  );

  sync_to_count #(
    .TOTAL_COLS(TOTAL_COLS),
    .TOTAL_ROWS(TOTAL_ROWS)
  ) u_sync_to_count (
    .i_Clk   (i_Clk),
    .i_arst_n(i_arst_n),
    .i_HSync (w_gen_hsync),
    .i_VSync (w_gen_vsync),
    .o_HSync (w_hsync_d),
    .o_VSync (w_vsync_d),
    .o_Col   (w_col),
    .o_Row   (w_row),
    .o_Locked(w_locked)
  );

  //////////////////////////////
  // Colour channels
  //////////////////////////////

  for (genvar g_ch = 0; g_ch < 3; g_ch++)
  begin : g_channel
    pattern_channel #(
      .CHANNEL     (g_ch),
      .ACTIVE_COLS (ACTIVE_COLS),
      .ACTIVE_ROWS (ACTIVE_ROWS),
      .CHECKER_LOG2(CHECKER_LOG2)
    ) u_pattern_channel (
      .i_Clk    (i_Clk),
      .i_arst_n (i_arst_n),
      .i_Pattern(i_Pattern),
      .i_Col    (w_col),
      .i_Row    (w_row),
      .o_Video  (w_rgb[g_ch])
    );
  end

  assign o_Red_Video = w_rgb[0];
  assign o_Grn_Video = w_rgb[1];
  assign o_Blu_Video = w_rgb[2];

  // Syncs and lock wait one cycle for the pixel register
  video_out_align u_video_out_align (
    .i_Clk   (i_Clk),
    .i_arst_n(i_arst_n),
    .i_HSync (w_hsync_d),
    .i_VSync (w_vsync_d),
    .i_Locked(w_locked),
    .o_HSync (o_HSync),
    .o_VSync (o_VSync),
    .o_Locked(o_Locked)
  );

endmodule

//--- logic/video_out_align.sv
`timescale 1ns/1ps

module video_out_align (
  input  logic i_Clk,
  input  logic i_arst_n,
  input  logic i_HSync,
  input  logic i_VSync,
  input  logic i_Locked,
  output logic o_HSync,
  output logic o_VSync,
  output logic o_Locked
);

  //////////////////////////////
  // Output alignment
  //////////////////////////////

  // The channel units register the pixel once
  // Same single stage here so syncs leave with their pixel

  // Syncs and lock are level signals, no edge logic needed
  always_ff @(posedge i_Clk or negedge i_arst_n)
  begin
    if (!i_arst_n)
    begin
      // Inactive levels while in reset
      o_HSync  <= 1'b0;
      o_VSync  <= 1'b0;
      o_Locked <= 1'b0;
    end
    else
    begin
      // Horizontal level for the pixel now leaving
      o_HSync  <= i_HSync;
      // Vertical level, first high cycle carries (0,0)
      o_VSync  <= i_VSync;
      // Lock rides along with the first frame
      o_Locked <= i_Locked;
    end
  end

endmodule

//--- logic/pattern_channel.sv
`timescale 1ns/1ps

module pattern_channel #(
  parameter int CHANNEL      = 0,
  parameter int ACTIVE_COLS  = 640,
  parameter int ACTIVE_ROWS  = 480,
  parameter int CHECKER_LOG2 = 5
) (
  input  logic              i_Clk,
  input  logic              i_arst_n,
  input  tpg_pkg::pattern_e i_Pattern,
  input  tpg_pkg::count_t   i_Col,
  input  tpg_pkg::count_t   i_Row,
  output tpg_pkg::video_t   o_Video
);

  import tpg_pkg::*;

  // All ones for this component
  localparam video_t FULL_SCALE = '1;

  // Solid pattern that lights this unit, 0 red, 1 green, 2 blue
  localparam pattern_e OWN_PAT = pattern_e'((CHANNEL == 0) ? PAT_RED :
                                            (CHANNEL == 1) ? PAT_GREEN : PAT_BLUE);

  // Eight equal bars across the active width
  localparam int BAR_WIDTH = ACTIVE_COLS / 8;

  // Bar index bit for this colour, red is the MSB
  localparam int BAR_BIT = 2 - CHANNEL;

  logic       w_active;
  logic       w_checker;
  logic       w_border;
  count_t     w_bar_quot;
  logic [2:0] w_bar_idx;
  video_t     w_next;

  //////////////////////////////
  // Pattern terms
  //////////////////////////////

  // Inside the visible area
  assign w_active = (i_Col < ACTIVE_COLS) && (i_Row < ACTIVE_ROWS);

  // Squares flip colour every 2**CHECKER_LOG2 pixels
  assign w_checker = i_Col[CHECKER_LOG2] ^ i_Row[CHECKER_LOG2];

  // Last bar absorbs any leftover columns
  assign w_bar_quot = i_Col / count_t'(BAR_WIDTH);
  assign w_bar_idx  = (w_bar_quot > count_t'(7)) ? 3'd7 : w_bar_quot[2:0];

  // Two pixel frame along all four edges
  assign w_border = (i_Row < 2) || (i_Row >= ACTIVE_ROWS - 2) ||
                    (i_Col < 2) || (i_Col >= ACTIVE_COLS - 2);

  //////////////////////////////
  // Pattern select
  //////////////////////////////

  always_comb
  begin
    w_next = '0;
    // Blanking stays black whatever the pattern
    if (w_active)
    begin
      case (i_Pattern)
        PAT_RED, PAT_GREEN, PAT_BLUE:
        begin
          // Only the matching colour lights up
          if (i_Pattern == OWN_PAT)
            w_next = FULL_SCALE;
        end
        PAT_CHECKER:
        begin
          if (w_checker)
            w_next = FULL_SCALE;
        end
        PAT_BARS:
        begin
          // 0 black, 1 blue, 2 green, 4 red, 7 white
          if (w_bar_idx[BAR_BIT])
            w_next = FULL_SCALE;
        end
        PAT_BORDER:
        begin
          if (w_border)
            w_next = FULL_SCALE;
        end
        // Off and the unused codes
        default: w_next = '0;
      endcase
    end
  end

  // One cycle from count to pixel
  always_ff @(posedge i_Clk or negedge i_arst_n)
  begin
    if (!i_arst_n)
      o_Video <= '0;
    else
      o_Video <= w_next;
  end

endmodule

//--- logic/sync_to_count.sv
`timescale 1ns/1ps

module sync_to_count #(
  parameter int TOTAL_COLS = 800,
  parameter int TOTAL_ROWS = 525
) (
  input  logic            i_Clk,
  input  logic            i_arst_n,
  input  logic            i_HSync,
  input  logic            i_VSync,
  output logic            o_HSync,
  output logic            o_VSync,
  output tpg_pkg::count_t o_Col,
  output tpg_pkg::count_t o_Row,
  output logic            o_Locked
);

  import tpg_pkg::*;

  // Last raster position, also the parking spot before lock
  localparam count_t LAST_COL = count_t'(TOTAL_COLS - 1);
  localparam count_t LAST_ROW = count_t'(TOTAL_ROWS - 1);

  // VSync history for edge detection
  logic        r_vsync_prev;
  logic        w_frame_start;
  lock_state_e r_state;

  // One cycle pulse at the start of every frame
  assign w_frame_start = i_VSync & ~r_vsync_prev;

  //////////////////////////////
  // Lock FSM
  //////////////////////////////

  always_ff @(posedge i_Clk or negedge i_arst_n)
  begin
    if (!i_arst_n)
    begin
      r_state      <= LOCK_WAIT;
      r_vsync_prev <= 1'b0;
    end
    else
    begin
      r_vsync_prev <= i_VSync;
      // First frame start locks, nothing unlocks afterwards
      if (r_state == LOCK_WAIT && w_frame_start)
        r_state <= LOCK_RUN;
    end
  end

  // Rises on the same edge that first loads (0,0)
  assign o_Locked = (r_state == LOCK_RUN);

  //////////////////////////////
  // Column and row counters
  //////////////////////////////

  // Syncs are registered here too so they stay with the counts
  // Counters sit at the last position until the first frame start,
  // which keeps the pixel path black while unlocked
  always_ff @(posedge i_Clk or negedge i_arst_n)
  begin
    if (!i_arst_n)
    begin
      o_HSync <= 1'b0;
      o_VSync <= 1'b0;
      o_Col   <= LAST_COL;
      o_Row   <= LAST_ROW;
    end
    else
    begin
      o_HSync <= i_HSync;
      o_VSync <= i_VSync;
      if (w_frame_start)
      begin
        // Frame start always realigns to the top left
        o_Col <= '0;
        o_Row <= '0;
      end
      else if (r_state == LOCK_RUN)
      begin
        if (o_Col == LAST_COL)
        begin
          o_Col <= '0;
          o_Row <= (o_Row == LAST_ROW) ? '0 : o_Row + 1'b1;
        end
        else
        begin
          o_Col <= o_Col + 1'b1;
        end
      end
    end
  end

endmodule

//--- logic/vga_sync_gen.sv
`timescale 1ns/1ps

module vga_sync_gen #(
  parameter int TOTAL_COLS  = 800,
  parameter int TOTAL_ROWS  = 525,
  parameter int ACTIVE_COLS = 640,
  parameter int ACTIVE_ROWS = 480
) (
  input  logic i_Clk,
  input  logic i_arst_n,
  output logic o_HSync,
  output logic o_VSync
);

  import tpg_pkg::*;

  // Last positions before each counter wraps
  localparam count_t LAST_COL = count_t'(TOTAL_COLS - 1);
  localparam count_t LAST_ROW = count_t'(TOTAL_ROWS - 1);

  // Raster position over the full frame, blanking included
  count_t r_col;
  count_t r_row;

  //////////////////////////////
  // Raster counters
  //////////////////////////////

  // Column runs every cycle, row steps on each column wrap
  always_ff @(posedge i_Clk or negedge i_arst_n)
  begin
    if (!i_arst_n)
    begin
      r_col <= '0;
      r_row <= '0;
    end
    else
    begin
      if (r_col == LAST_COL)
      begin
        r_col <= '0;
        // End of line, move down or back to the top
        if (r_row == LAST_ROW)
          r_row <= '0;
        else
          r_row <= r_row + 1'b1;
      end
      else
      begin
        r_col <= r_col + 1'b1;
      end
    end
  end

  //////////////////////////////
  // Sync levels
  //////////////////////////////

  // High while inside the active columns and rows
  // Registered, so they lag the counters by one cycle
  always_ff @(posedge i_Clk or negedge i_arst_n)
  begin
    if (!i_arst_n)
    begin
      o_HSync <= 1'b0;
      o_VSync <= 1'b0;
    end
    else
    begin
      o_HSync <= (r_col < ACTIVE_COLS);
      o_VSync <= (r_row < ACTIVE_ROWS);
    end
  end

endmodule

//--- logic/tpg_pkg.sv
package tpg_pkg;

  //////////////////////////////
  // Video widths
  //////////////////////////////

  // Bits per colour component
  // Fixed here since video_t needs a constant width
  localparam int unsigned VIDEO_WIDTH = 3;

  // One colour component of a pixel
  typedef logic [VIDEO_WIDTH-1:0] video_t;

  // Column or row position, good up to 1023
  typedef logic [9:0] count_t;

  //////////////////////////////
  // Pattern codes
  //////////////////////////////

  // Codes 7 to 15 are not listed and behave like PAT_OFF
  typedef enum logic [3:0] {
    PAT_OFF     = 4'd0,
    PAT_RED     = 4'd1,
    PAT_GREEN   = 4'd2,
    PAT_BLUE    = 4'd3,
    PAT_CHECKER = 4'd4,
    PAT_BARS    = 4'd5,
    PAT_BORDER  = 4'd6
  } pattern_e;

  //////////////////////////////
  // Lock FSM
  //////////////////////////////

  // Waiting for the first frame start, then running for good
  typedef enum logic {
    LOCK_WAIT = 1'b0,
    LOCK_RUN  = 1'b1
  } lock_state_e;

endpackage
